//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_axil_read_mux
FLIST     ?= axil_read_mux.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

//--- axil_read_mux.f
design/axil_pkg.sv
design/axil_rr_arbiter.sv
design/axil_order_fifo.sv
design/axil_reg_slice.sv
design/axil_read_ctrl.sv
design/axil_read_mux.sv
dv/axil_read_checker.sv
dv/tb_axil_read_mux.sv

//--- design/axil_order_fifo.sv
`timescale 1ns/1ns

module axil_order_fifo #(
  parameter int unsigned NumPorts = axil_pkg::DEF_NUM_PORTS,
  parameter int unsigned MaxTrans = axil_pkg::DEF_MAX_TRANS
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        push_i,
  input  logic [$clog2(NumPorts)-1:0] idx_i,
  input  logic                        pop_i,
  output logic [$clog2(NumPorts)-1:0] idx_o,
  output logic                        full_o,
  output logic                        empty_o
);

  localparam int unsigned IdxW = $clog2(NumPorts);
  localparam int unsigned PtrW = (MaxTrans > 1) ? $clog2(MaxTrans) : 1;
  localparam int unsigned CntW = $clog2(MaxTrans + 1);

  typedef logic [IdxW-1:0] idx_t;
  typedef logic [PtrW-1:0] ptr_t;

  // Port index per outstanding read
  idx_t mem_q [MaxTrans];

  ptr_t            wr_ptr_q;
  ptr_t            rd_ptr_q;
  logic [CntW-1:0] cnt_q;

  // Status from the entry count
  assign full_o  = (cnt_q == CntW'(MaxTrans));
  assign empty_o = (cnt_q == '0);
  assign idx_o   = mem_q[rd_ptr_q];

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(MaxTrans - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(MaxTrans - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Both at once leaves the count alone
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Storage write
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= idx_i;
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> !full_o);

  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> !empty_o);

  // Push into an empty FIFO shows at the head next cycle
  a_push_to_head: assert property (@(posedge clk_i) disable iff (rst_i)
    (push_i && empty_o) |=> (idx_o == $past(idx_i)));

endmodule

//--- design/axil_pkg.sv
package axil_pkg;

  // --------------------
  // Basic field types
  // --------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [2:0]  prot_t;
  typedef logic [1:0]  resp_t;

  // Response codes in use
  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // --------------------
  // Read channel payloads
  // --------------------
  // AR payload, addr in the upper bits
  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } ar_chan_t;

  // R payload, data in the upper bits
  typedef struct packed {
    data_t data;
    resp_t resp;
  } r_chan_t;

  // Defaults for the top level
  localparam int unsigned DEF_NUM_PORTS = 4;
  localparam int unsigned DEF_MAX_TRANS = 4;

endpackage

//--- design/axil_read_ctrl.sv
`timescale 1ns/1ns

module axil_read_ctrl #(
  parameter int unsigned NumPorts = axil_pkg::DEF_NUM_PORTS
) (
  // AR side
  input  logic                        arb_req_i,
  input  logic [$clog2(NumPorts)-1:0] arb_idx_i,
  output logic                        arb_gnt_o,
  output logic                        slice_valid_o,
  input  logic                        slice_ready_i,
  // Order FIFO
  output logic                        fifo_push_o,
  output logic [$clog2(NumPorts)-1:0] fifo_idx_o,
  input  logic                        fifo_full_i,
  input  logic                        fifo_empty_i,
  input  logic [$clog2(NumPorts)-1:0] fifo_idx_i,
  output logic                        fifo_pop_o,
  // R side
  input  logic                        r_valid_i,
  output logic                        r_ready_o,
  output logic [NumPorts-1:0]         r_valid_o,
  input  logic [NumPorts-1:0]         r_ready_i
);

  localparam int unsigned IdxW = $clog2(NumPorts);

  // --------------------
  // AR gating
  // --------------------
  // No new read without a free FIFO slot
  assign slice_valid_o = arb_req_i & ~fifo_full_i;
  assign arb_gnt_o     = slice_ready_i & ~fifo_full_i;

  // Record winner on the slice transfer
  assign fifo_push_o = slice_valid_o & slice_ready_i;
  assign fifo_idx_o  = arb_idx_i;

  // --------------------
  // R routing
  // --------------------
  // Only the oldest issuer sees valid
  for (genvar i = 0; i < NumPorts; i++) begin : gen_r_valid
    assign r_valid_o[i] = r_valid_i & ~fifo_empty_i & (fifo_idx_i == IdxW'(i));
  end

  // Ready follows the head port
  assign r_ready_o  = ~fifo_empty_i & r_ready_i[fifo_idx_i];
  // Head retires with its response
  assign fifo_pop_o = r_valid_i & r_ready_o;

endmodule

//--- design/axil_read_mux.sv
`timescale 1ns/1ns

module axil_read_mux #(
  parameter int unsigned NumPorts = axil_pkg::DEF_NUM_PORTS,
  parameter int unsigned MaxTrans = axil_pkg::DEF_MAX_TRANS
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // Upstream manager ports
  input  axil_pkg::ar_chan_t [NumPorts-1:0]   slv_ar_i,
  input  logic               [NumPorts-1:0]   slv_ar_valid_i,
  output logic               [NumPorts-1:0]   slv_ar_ready_o,
  output axil_pkg::r_chan_t                   slv_r_o,
  output logic               [NumPorts-1:0]   slv_r_valid_o,
  input  logic               [NumPorts-1:0]   slv_r_ready_i,
  // Downstream subordinate port
  output axil_pkg::ar_chan_t                  mst_ar_o,
  output logic                                mst_ar_valid_o,
  input  logic                                mst_ar_ready_i,
  input  axil_pkg::r_chan_t                   mst_r_i,
  input  logic                                mst_r_valid_i,
  output logic                                mst_r_ready_o
);

  import axil_pkg::*;

  localparam int unsigned IdxW = $clog2(NumPorts);

  // Elaboration checks
  if (NumPorts < 2) begin : gen_chk_ports
    $error("axil_read_mux needs NumPorts of at least 2");
  end
  if (MaxTrans < 1) begin : gen_chk_trans
    $error("axil_read_mux needs MaxTrans of at least 1");
  end

  // Arbiter to control
  ar_chan_t        arb_ar;
  logic [IdxW-1:0] arb_idx;
  logic            arb_req;
  logic            arb_gnt;
  // Control to AR slice
  logic            slice_valid;
  logic            slice_ready;
  // Order FIFO
  logic            fifo_push;
  logic [IdxW-1:0] fifo_push_idx;
  logic            fifo_pop;
  logic            fifo_full;
  logic            fifo_empty;
  logic [IdxW-1:0] fifo_head_idx;
  // R slice to control
  logic            r_valid;
  logic            r_ready;

  // --------------------
  // AR path
  // --------------------
  axil_rr_arbiter #(
    .NumPorts (NumPorts)
  ) u_arbiter (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (slv_ar_valid_i),
    .ar_i  (slv_ar_i),
    .gnt_i (arb_gnt),
    .gnt_o (slv_ar_ready_o),
    .req_o (arb_req),
    .ar_o  (arb_ar),
    .idx_o (arb_idx)
  );

  axil_reg_slice #(
    .payload_t (ar_chan_t)
  ) u_ar_slice (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (slice_valid),
    .ready_o (slice_ready),
    .data_i  (arb_ar),
    .valid_o (mst_ar_valid_o),
    .ready_i (mst_ar_ready_i),
    .data_o  (mst_ar_o)
  );

  // --------------------
  // Issue order and control
  // --------------------
  axil_order_fifo #(
    .NumPorts (NumPorts),
    .MaxTrans (MaxTrans)
  ) u_order_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (fifo_push),
    .idx_i   (fifo_push_idx),
    .pop_i   (fifo_pop),
    .idx_o   (fifo_head_idx),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  axil_read_ctrl #(
    .NumPorts (NumPorts)
  ) u_read_ctrl (
    .arb_req_i     (arb_req),
    .arb_idx_i     (arb_idx),
    .arb_gnt_o     (arb_gnt),
    .slice_valid_o (slice_valid),
    .slice_ready_i (slice_ready),
    .fifo_push_o   (fifo_push),
    .fifo_idx_o    (fifo_push_idx),
    .fifo_full_i   (fifo_full),
    .fifo_empty_i  (fifo_empty),
    .fifo_idx_i    (fifo_head_idx),
    .fifo_pop_o    (fifo_pop),
    .r_valid_i     (r_valid),
    .r_ready_o     (r_ready),
    .r_valid_o     (slv_r_valid_o),
    .r_ready_i     (slv_r_ready_i)
  );

  // --------------------
  // R path
  // --------------------
  // Payload goes to every port, valid is per port
  axil_reg_slice #(
    .payload_t (r_chan_t)
  ) u_r_slice (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (mst_r_valid_i),
    .ready_o (mst_r_ready_o),
    .data_i  (mst_r_i),
    .valid_o (r_valid),
    .ready_i (r_ready),
    .data_o  (slv_r_o)
  );

endmodule

//--- design/axil_reg_slice.sv
`timescale 1ns/1ns

module axil_reg_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  // Output entry, drives the downstream side
  logic     main_valid_q;
  payload_t main_data_q;
  // Skid entry, catches data during a stall
  logic     skid_valid_q;
  payload_t skid_data_q;

  logic out_free;
  logic load_main;
  logic load_skid;

  // --------------------
  // Handshake decode
  // --------------------
  // Output entry empties or moves on this edge
  assign out_free  = ~main_valid_q | ready_i;
  // Skid drains first, keeps order
  assign load_main = out_free & (skid_valid_q | valid_i);
  // Park input when output is stuck
  assign load_skid = ~out_free & valid_i & ~skid_valid_q;

  // Accept while one entry free
  assign ready_o = ~skid_valid_q;
  assign valid_o = main_valid_q;
  assign data_o  = main_data_q;

  // --------------------
  // Valid state
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else begin
      if (out_free) begin
        main_valid_q <= skid_valid_q | valid_i;
      end
      if (skid_valid_q) begin
        // Drains into the output entry once free
        skid_valid_q <= ~out_free;
      end else begin
        skid_valid_q <= load_skid;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    if (load_main) begin
      main_data_q <= skid_valid_q ? skid_data_q : data_i;
    end
    if (load_skid) begin
      skid_data_q <= data_i;
    end
  end

  // Stalled output holds valid and payload
  a_hold_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(data_o)));

  // Skid only fills behind a full output entry
  a_skid_order: assert property (@(posedge clk_i) disable iff (rst_i)
    skid_valid_q |-> main_valid_q);

endmodule

//--- design/axil_rr_arbiter.sv
`timescale 1ns/1ns

module axil_rr_arbiter #(
  parameter int unsigned NumPorts = axil_pkg::DEF_NUM_PORTS
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic               [NumPorts-1:0]   req_i,
  input  axil_pkg::ar_chan_t [NumPorts-1:0]   ar_i,
  input  logic                                gnt_i,
  output logic               [NumPorts-1:0]   gnt_o,
  output logic                                req_o,
  output axil_pkg::ar_chan_t                  ar_o,
  output logic [$clog2(NumPorts)-1:0]         idx_o
);

  localparam int unsigned IdxW = $clog2(NumPorts);

  typedef logic [IdxW-1:0] idx_t;

  // Round-robin pointer, first port to look at
  idx_t rr_q;
  // Held choice while the downstream stalls
  logic lock_q;
  idx_t lock_idx_q;

  logic pick_found;
  idx_t pick_idx;
  idx_t sel_idx;

  // --------------------
  // Search from pointer
  // --------------------
  always_comb begin
    int unsigned cand;
    pick_found = 1'b0;
    pick_idx   = rr_q;
    for (int unsigned k = 0; k < NumPorts; k++) begin
      // Wrap around the port range
      cand = (rr_q + k) % NumPorts;
      if (!pick_found && req_i[cand]) begin
        pick_found = 1'b1;
        pick_idx   = idx_t'(cand);
      end
    end
  end

  // Locked choice wins over a fresh search
  assign sel_idx = lock_q ? lock_idx_q : pick_idx;
  assign req_o   = lock_q ? req_i[lock_idx_q] : pick_found;
  assign ar_o    = ar_i[sel_idx];
  assign idx_o   = sel_idx;

  // One-hot grant back to the winner
  for (genvar i = 0; i < NumPorts; i++) begin : gen_gnt
    assign gnt_o[i] = gnt_i & req_o & (sel_idx == idx_t'(i));
  end

  // --------------------
  // Pointer and lock state
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      // Hold on a pending request, release on transfer
      lock_q     <= req_o & ~gnt_i;
      lock_idx_q <= sel_idx;
      if (req_o && gnt_i) begin
        // Next search starts after the winner
        rr_q <= (sel_idx == idx_t'(NumPorts - 1)) ? '0 : sel_idx + 1'b1;
      end
    end
  end

  // Grant only reaches a requesting port
  a_gnt_requested: assert property (@(posedge clk_i) disable iff (rst_i)
    (gnt_o & ~req_i) == '0);

  // Stalled request stays up on the same port with the same payload
  a_lock_in: assert property (@(posedge clk_i) disable iff (rst_i)
    (req_o && !gnt_i) |=> (req_o && $stable(idx_o) && $stable(ar_o)));

endmodule

//--- dv/axil_read_checker.sv
`timescale 1ns/1ns

module axil_read_checker #(
  parameter int unsigned NumPorts = 4,
  parameter int unsigned MaxTrans = 4
) (
  input logic                                clk_i,
  input logic                                rst_i,
  input axil_pkg::ar_chan_t [NumPorts-1:0]   slv_ar_i,
  input logic               [NumPorts-1:0]   slv_ar_valid_i,
  input logic               [NumPorts-1:0]   slv_ar_ready_o,
  input axil_pkg::r_chan_t                   slv_r_o,
  input logic               [NumPorts-1:0]   slv_r_valid_o,
  input logic               [NumPorts-1:0]   slv_r_ready_i,
  input axil_pkg::ar_chan_t                  mst_ar_o,
  input logic                                mst_ar_valid_o,
  input logic                                mst_ar_ready_i,
  input logic                                mst_r_valid_i,
  input logic                                mst_r_ready_o
);

  import axil_pkg::*;

  // Subordinate data rule
  localparam data_t DataKey = 32'h5A5A_0000;

  // Addresses per port, oldest first
  addr_t       issued_q [NumPorts][$];
  // Accepted upstream ARs in grant order
  ar_chan_t    fwd_q[$];
  int unsigned fwd_port_q[$];
  // Grant order the current test expects
  int unsigned exp_grant_q[$];

  int unsigned err_cnt = 0;
  int unsigned reads_done = 0;
  int unsigned out_cnt = 0;
  int unsigned tests_pass = 0;
  int unsigned tests_fail = 0;
  int unsigned err_mark = 0;
  int unsigned read_mark = 0;

  // --------------------
  // Sampling at negedge
  // --------------------
  // Handshakes seen here complete at the next rising edge
  always @(negedge clk_i) begin
    ar_chan_t    exp_ar;
    int unsigned port;
    int unsigned exp_port;
    addr_t       addr;
    data_t       exp_data;
    resp_t       exp_resp;
    if (rst_i) begin
      out_cnt = 0;
    end else begin
      for (int p = 0; p < NumPorts; p++) begin
        if (slv_ar_valid_i[p] && slv_ar_ready_o[p]) begin
          issued_q[p].push_back(slv_ar_i[p].addr);
          fwd_q.push_back(slv_ar_i[p]);
          fwd_port_q.push_back(p);
        end
      end
      // Downstream AR must match the oldest granted upstream AR
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        if (fwd_q.size() == 0) begin
          note_failure("downstream AR seen with no upstream request behind it");
        end else begin
          exp_ar = fwd_q.pop_front();
          port   = fwd_port_q.pop_front();
          if (mst_ar_o !== exp_ar) begin
            $display("MISMATCH t=%0t mst_ar_o expected %h actual %h", $time, exp_ar, mst_ar_o);
            err_cnt++;
          end
          if (exp_grant_q.size() != 0) begin
            exp_port = exp_grant_q.pop_front();
            if (exp_port != port) begin
              $display("MISMATCH t=%0t grant_port expected %0d actual %0d",
                       $time, exp_port, port);
              err_cnt++;
            end
          end
        end
        out_cnt++;
        if (out_cnt > MaxTrans) begin
          note_failure("more downstream reads outstanding than the limit allows");
        end
      end
      if (mst_r_valid_i && mst_r_ready_o && out_cnt != 0) begin
        out_cnt--;
      end
      // Only the head port may see R valid
      if ($countones(slv_r_valid_o) > 1) begin
        note_failure("R valid raised on more than one port");
      end
      for (int p = 0; p < NumPorts; p++) begin
        if (slv_r_valid_o[p] && slv_r_ready_i[p]) begin
          if (issued_q[p].size() == 0) begin
            note_failure("R response on a port with no read outstanding");
          end else begin
            addr     = issued_q[p].pop_front();
            exp_data = addr ^ DataKey;
            exp_resp = addr[31] ? RESP_SLVERR : RESP_OKAY;
            if (slv_r_o.data !== exp_data) begin
              $display("MISMATCH t=%0t slv_r_o.data port %0d expected %h actual %h",
                       $time, p, exp_data, slv_r_o.data);
              err_cnt++;
            end
            if (slv_r_o.resp !== exp_resp) begin
              $display("MISMATCH t=%0t slv_r_o.resp port %0d expected %h actual %h",
                       $time, p, exp_resp, slv_r_o.resp);
              err_cnt++;
            end
          end
          reads_done++;
        end
      end
    end
  end

  // --------------------
  // Test bookkeeping
  // --------------------
  task automatic note_failure(input string msg);
    $display("ERROR t=%0t %s", $time, msg);
    err_cnt++;
  endtask

  task automatic expect_grant(input int unsigned port);
    exp_grant_q.push_back(port);
  endtask

  task automatic finish_test(input string name);
    int unsigned errs;
    if (exp_grant_q.size() != 0) begin
      note_failure("expected grant order was not fully seen");
      exp_grant_q.delete();
    end
    errs = err_cnt - err_mark;
    if (errs == 0) begin
      tests_pass++;
    end else begin
      tests_fail++;
    end
    $display("test %s: %s, reads %0d, errors %0d", name, (errs == 0) ? "pass" : "FAIL",
             reads_done - read_mark, errs);
    err_mark  = err_cnt;
    read_mark = reads_done;
  endtask

  task automatic final_report();
    $display("tests passed %0d, tests failed %0d, errors %0d", tests_pass, tests_fail, err_cnt);
  endtask

endmodule

//--- dv/tb_axil_read_mux.sv
`timescale 1ns/1ns

module tb_axil_read_mux;

  import axil_pkg::*;

  localparam int unsigned NumPorts = 4;
  localparam int unsigned MaxTrans = 4;
  localparam int unsigned Timeout  = 2000;
  localparam data_t       DataKey  = 32'h5A5A_0000;

  // One row per test
  typedef struct {
    string       name;
    int unsigned nper;
    logic [3:0]  port_en;
    logic        seq;
    int unsigned mode;
    int unsigned n_order;
    int unsigned order[4];
    addr_t       base;
  } test_row_t;

  logic                         clk_i = 1'b0;
  logic                         rst_i = 1'b1;
  ar_chan_t    [NumPorts-1:0]   slv_ar_i = '0;
  logic        [NumPorts-1:0]   slv_ar_valid_i = '0;
  logic        [NumPorts-1:0]   slv_ar_ready_o;
  r_chan_t                      slv_r_o;
  logic        [NumPorts-1:0]   slv_r_valid_o;
  logic        [NumPorts-1:0]   slv_r_ready_i = '0;
  ar_chan_t                     mst_ar_o;
  logic                         mst_ar_valid_o;
  logic                         mst_ar_ready_i = 1'b0;
  r_chan_t                      mst_r_i = '0;
  logic                         mst_r_valid_i = 1'b0;
  logic                         mst_r_ready_o;

  test_row_t   rows[8];
  addr_t       port_q [NumPorts][$];
  addr_t       sub_q[$];
  // Mode 0 plain, 1 random stalls, 2 responses held
  int unsigned stall_mode = 0;
  logic        hold_resp = 1'b0;
  logic        timed_out = 1'b0;
  logic [16:0] lfsr_q = 17'd76947;

  // Handshakes due at the next rising edge
  logic [NumPorts-1:0] up_ar_fire = '0;
  logic                dn_ar_fire = 1'b0;
  logic                dn_r_fire = 1'b0;
  addr_t               dn_ar_addr = '0;

  always #10 clk_i = ~clk_i;

  axil_read_mux #(
    .NumPorts (NumPorts),
    .MaxTrans (MaxTrans)
  ) u_axil_read_mux (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .slv_ar_i       (slv_ar_i),
    .slv_ar_valid_i (slv_ar_valid_i),
    .slv_ar_ready_o (slv_ar_ready_o),
    .slv_r_o        (slv_r_o),
    .slv_r_valid_o  (slv_r_valid_o),
    .slv_r_ready_i  (slv_r_ready_i),
    .mst_ar_o       (mst_ar_o),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_ready_i (mst_ar_ready_i),
    .mst_r_i        (mst_r_i),
    .mst_r_valid_i  (mst_r_valid_i),
    .mst_r_ready_o  (mst_r_ready_o)
  );

  axil_read_checker #(
    .NumPorts (NumPorts),
    .MaxTrans (MaxTrans)
  ) u_checker (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .slv_ar_i       (slv_ar_i),
    .slv_ar_valid_i (slv_ar_valid_i),
    .slv_ar_ready_o (slv_ar_ready_o),
    .slv_r_o        (slv_r_o),
    .slv_r_valid_o  (slv_r_valid_o),
    .slv_r_ready_i  (slv_r_ready_i),
    .mst_ar_o       (mst_ar_o),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_ready_i (mst_ar_ready_i),
    .mst_r_valid_i  (mst_r_valid_i),
    .mst_r_ready_o  (mst_r_ready_o)
  );

  // Fibonacci LFSR, taps 17 and 14
  function automatic logic next_rand_bit();
    logic fb;
    fb     = lfsr_q[16] ^ lfsr_q[13];
    lfsr_q = {lfsr_q[15:0], fb};
    return fb;
  endfunction

  // Port in bits 9:8, read number in bits 7:4
  function automatic addr_t row_addr(addr_t base, int unsigned p, int unsigned k);
    return base + addr_t'(p << 8) + addr_t'(k << 4);
  endfunction

  // --------------------
  // Handshake sampling
  // --------------------
  always @(negedge clk_i) begin
    up_ar_fire = slv_ar_valid_i & slv_ar_ready_o;
    dn_ar_fire = mst_ar_valid_o & mst_ar_ready_i;
    dn_r_fire  = mst_r_valid_i & mst_r_ready_o;
    dn_ar_addr = mst_ar_o.addr;
  end

  // --------------------
  // Managers and subordinate
  // --------------------
  always @(posedge clk_i) begin
    #1;
    if (!rst_i) begin
      for (int p = 0; p < NumPorts; p++) begin
        if (up_ar_fire[p]) begin
          void'(port_q[p].pop_front());
        end
        // Next address held until accepted
        slv_ar_valid_i[p] = (port_q[p].size() != 0);
        if (port_q[p].size() != 0) begin
          slv_ar_i[p].addr = port_q[p][0];
          slv_ar_i[p].prot = 3'(p);
        end
        slv_r_ready_i[p] = (stall_mode == 1) ? next_rand_bit() : 1'b1;
      end
      if (dn_ar_fire) begin
        sub_q.push_back(dn_ar_addr);
      end
      if (dn_r_fire) begin
        void'(sub_q.pop_front());
        mst_r_valid_i = 1'b0;
      end
      mst_ar_ready_i = (stall_mode == 1) ? next_rand_bit() : 1'b1;
      // Responses in order, data from the address rule
      if (!mst_r_valid_i && sub_q.size() != 0 && !hold_resp) begin
        if (stall_mode != 1 || next_rand_bit()) begin
          mst_r_valid_i = 1'b1;
          mst_r_i.data  = sub_q[0] ^ DataKey;
          mst_r_i.resp  = sub_q[0][31] ? RESP_SLVERR : RESP_OKAY;
        end
      end
    end
  end

  // --------------------
  // Waits with timeout
  // --------------------
  task automatic wait_reads(input int unsigned target);
    int unsigned cyc;
    cyc = 0;
    while (u_checker.reads_done < target && cyc < Timeout) begin
      @(posedge clk_i);
      cyc++;
    end
    if (u_checker.reads_done < target) begin
      u_checker.note_failure("timeout while waiting for read responses");
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_outstanding(input int unsigned target);
    int unsigned cyc;
    cyc = 0;
    while (u_checker.out_cnt < target && cyc < Timeout) begin
      @(posedge clk_i);
      cyc++;
    end
    if (u_checker.out_cnt < target) begin
      u_checker.note_failure("timeout while waiting for outstanding reads to build up");
      timed_out = 1'b1;
    end
  endtask

  task automatic run_test(input int unsigned idx);
    test_row_t   row;
    int unsigned base;
    int unsigned nreads;
    row        = rows[idx];
    base       = u_checker.reads_done;
    nreads     = 0;
    stall_mode = row.mode;
    hold_resp  = (row.mode == 2);
    for (int unsigned k = 0; k < row.n_order; k++) begin
      u_checker.expect_grant(row.order[k]);
    end
    for (int unsigned p = 0; p < NumPorts; p++) begin
      if (row.port_en[p]) begin
        for (int unsigned k = 0; k < row.nper; k++) begin
          port_q[p].push_back(row_addr(row.base, p, k));
          nreads++;
          // One port at a time, each read to completion
          if (row.seq) begin
            wait_reads(base + nreads);
            if (timed_out) begin
              return;
            end
          end
        end
      end
    end
    if (hold_resp) begin
      wait_outstanding(MaxTrans);
      if (timed_out) begin
        return;
      end
      repeat (10) @(posedge clk_i);
      hold_resp = 1'b0;
    end
    wait_reads(base + nreads);
    if (timed_out) begin
      return;
    end
    stall_mode = 0;
    u_checker.finish_test(row.name);
  endtask

  initial begin
    rows[0] = '{"all_four",    1, 4'hF, 1'b0, 0, 4, '{0, 1, 2, 3}, 32'h0000_2000};
    rows[1] = '{"single",      1, 4'hF, 1'b1, 0, 0, '{0, 0, 0, 0}, 32'h0000_1000};
    rows[2] = '{"port1_alone", 1, 4'h2, 1'b0, 0, 0, '{0, 0, 0, 0}, 32'h0000_3000};
    rows[3] = '{"after_port1", 1, 4'hF, 1'b0, 0, 4, '{2, 3, 0, 1}, 32'h0000_4000};
    rows[4] = '{"interleave",  3, 4'hF, 1'b0, 0, 4, '{2, 3, 0, 1}, 32'h0000_5000};
    rows[5] = '{"rand_stall",  4, 4'hF, 1'b0, 1, 0, '{0, 0, 0, 0}, 32'h0000_6000};
    rows[6] = '{"hold_resp",   2, 4'hF, 1'b0, 2, 0, '{0, 0, 0, 0}, 32'h0000_7000};
    rows[7] = '{"slverr",      1, 4'h4, 1'b0, 0, 0, '{0, 0, 0, 0}, 32'h8000_2000};
    // Reset for 4 cycles
    repeat (4) @(posedge clk_i);
    #1 rst_i = 1'b0;
    @(posedge clk_i);
    for (int unsigned i = 0; i < 8; i++) begin
      run_test(i);
      if (timed_out) begin
        break;
      end
    end
    u_checker.final_report();
    if (!timed_out && u_checker.err_cnt == 0 && u_checker.tests_fail == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
